// File: hdl/shade_pkg.sv
// normals are signed q2.14 and expected near unit length; intensity is never above 1.0; cfg_sel 3 is ignored
`default_nettype none

package shade_pkg;

  // normal component format, signed q2.14
  localparam int NORMAL_W    = 16;
  localparam int NORMAL_FRAC = 14;  // also the fraction of the intensity

  // 1.0 in q2.14, upper bound of the light intensity
  localparam logic [NORMAL_W-1:0] INTENSITY_ONE = 16'd16384;

  // x sits in the top bits, z in the bottom
  typedef struct packed {
    logic signed [NORMAL_W-1:0] x;
    logic signed [NORMAL_W-1:0] y;
    logic signed [NORMAL_W-1:0] z;
  } normal_t;  // 48 bits

  typedef struct packed {
    logic [4:0] r;  // red in [15:11]
    logic [5:0] g;  // green in [10:5]
    logic [4:0] b;  // blue in [4:0]
  } rgb565_t;

  // target of a config write
  localparam logic [1:0] CFG_SEL_TRI  = 2'd0;  // triangle table, color index + normal
  localparam logic [1:0] CFG_SEL_PAL  = 2'd1;  // palette, rgb565 in low bits
  localparam logic [1:0] CFG_SEL_CTRL = 2'd2;  // ambient and cull enable

  // control word layout, ambient in [15:0]
  localparam int CTRL_CULL_BIT = 16;

endpackage

`default_nettype wire

// File: hdl/delay_line.sv
// STAGES must be at least 1; every stage clears to zero on reset, payload included
`default_nettype none

module delay_line #(
  parameter int  STAGES = 2,
  parameter type T      = logic
) (
  input  logic clk_in,
  input  logic rst_in,
  input  T     d,
  output T     q
);

  T pipe [STAGES];  // pipe[0] is the first register after d

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < STAGES; i++) begin
        pipe[i] <= '0;  // valid bits come up low
      end
    end else begin
      pipe[0] <= d;
      for (int i = 1; i < STAGES; i++) begin
        pipe[i] <= pipe[i-1];  // shift one step per clock
      end
    end
  end

  assign q = pipe[STAGES-1];  // d after STAGES cycles

endmodule

`default_nettype wire

// File: hdl/table_ram.sv
// contents power up unknown and have no reset; a read and a write to one address return the old word
`default_nettype none

module table_ram #(
  parameter int DEPTH = 256,
  parameter int WIDTH = 16
) (
  input  logic                     clk_in,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  logic [WIDTH-1:0]         wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output logic [WIDTH-1:0]         rdata
);

  logic [WIDTH-1:0] mem [DEPTH];  // maps to block ram

  // write port
  always_ff @(posedge clk_in) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, sees the word from before a same-cycle write
  always_ff @(posedge clk_in) begin
    rdata <= mem[raddr];  // 1 cycle after raddr
  end

  // a write past the end would wrap onto a live entry
  a_waddr_in_range : assert property (
    @(posedge clk_in) we |-> (int'(waddr) < DEPTH)
  ) else $error("table_ram: write address %0d beyond depth %0d", waddr, DEPTH);

endmodule

`default_nettype wire

// File: hdl/light_dot.sv
// 3-cycle latency; ambient must not exceed 1.0 and is sampled at the last stage, not with the pixel
`default_nettype none

module light_dot (
  input  logic                clk_in,
  input  logic                rst_in,
  input  shade_pkg::normal_t  tri_normal,
  input  shade_pkg::normal_t  cam_normal,
  input  logic [15:0]         ambient,
  output logic [15:0]         intensity,
  output logic                front
);

  localparam int PROD_W = 2 * shade_pkg::NORMAL_W;  // one component product
  localparam int DOT_W  = PROD_W + 2;               // room for the sum of three

  localparam logic signed [DOT_W-1:0] ONE_EXT = DOT_W'(shade_pkg::INTENSITY_ONE);

  // stage 1 products
  logic signed [PROD_W-1:0] prod_x;
  logic signed [PROD_W-1:0] prod_y;
  logic signed [PROD_W-1:0] prod_z;

  // stage 2 sum and facing
  logic signed [DOT_W-1:0]  dot_sum_c;
  logic signed [DOT_W-1:0]  dot_sum;
  logic                     front_s2;

  // stage 3 combinational terms
  logic signed [DOT_W-1:0]  dot_shift;
  logic signed [DOT_W-1:0]  amb_ext;
  logic signed [DOT_W-1:0]  floored;
  logic [15:0]              clamped;

  always_ff @(posedge clk_in) begin
    prod_x <= tri_normal.x * cam_normal.x;  // signed q4.28
    prod_y <= tri_normal.y * cam_normal.y;
    prod_z <= tri_normal.z * cam_normal.z;
  end

  assign dot_sum_c = DOT_W'(prod_x) + DOT_W'(prod_y) + DOT_W'(prod_z);  // sign extended

  always_ff @(posedge clk_in) begin
    dot_sum <= dot_sum_c;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      front_s2 <= 1'b0;
      front    <= 1'b0;
    end else begin
      front_s2 <= (dot_sum_c > 0);  // test on the full sum, before the shift
      front    <= front_s2;
    end
  end

  always_comb begin
    dot_shift = dot_sum >>> shade_pkg::NORMAL_FRAC;  // back to q2.14, floors toward -inf
    amb_ext   = $signed({{(DOT_W-16){1'b0}}, ambient});  // ambient is never negative
    floored   = (dot_shift > amb_ext) ? dot_shift : amb_ext;
    if (floored > ONE_EXT) begin
      clamped = shade_pkg::INTENSITY_ONE;  // cap at 1.0
    end else begin
      clamped = floored[15:0];  // fits, 0 to 1.0
    end
  end

  always_ff @(posedge clk_in) begin
    intensity <= clamped;  // lines up with front
  end

  // channel_scale truncation relies on this bound
  a_intensity_max : assert property (
    @(posedge clk_in) disable iff (rst_in)
    !$isunknown(intensity) |-> (intensity <= shade_pkg::INTENSITY_ONE)
  ) else $error("light_dot: intensity %0d above 1.0", intensity);

endmodule

`default_nettype wire

// File: hdl/channel_scale.sv
// 2-cycle latency; intensity is unsigned q2.14 at most 1.0, so the result fits the channel width
`default_nettype none

module channel_scale #(
  parameter int CH_W = 5
) (
  input  logic            clk_in,
  input  logic            rst_in,
  input  logic [CH_W-1:0] channel,
  input  logic [15:0]     intensity,
  output logic [CH_W-1:0] scaled
);

  localparam int PROD_W = CH_W + 16;  // full unsigned product

  logic [PROD_W-1:0] prod;  // stage 1

  // stage 1, channel times intensity
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      prod <= '0;
    end else begin
      prod <= PROD_W'(channel) * PROD_W'(intensity);
    end
  end

  // stage 2, drop the fraction and keep CH_W bits
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      scaled <= '0;
    end else begin
      scaled <= prod[shade_pkg::NORMAL_FRAC +: CH_W];  // truncates, no rounding
    end
  end

endmodule

`default_nettype wire

// File: hdl/shade_cfg_regs.sv
// assumes NUM_TRI >= NUM_COLORS for the shared address; ambient writes above 1.0 are illegal
`default_nettype none

module shade_cfg_regs #(
  parameter int  NUM_TRI    = 2048,
  parameter int  NUM_COLORS = 256,
  localparam int TRI_AW     = $clog2(NUM_TRI),
  localparam int CIDX_W     = $clog2(NUM_COLORS),
  localparam int CFG_AW     = (TRI_AW > CIDX_W) ? TRI_AW : CIDX_W,
  localparam int CFG_DW     = 3 * shade_pkg::NORMAL_W + CIDX_W
) (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                cfg_we,
  input  logic [1:0]          cfg_sel,
  input  logic [CFG_AW-1:0]   cfg_addr,
  input  logic [CFG_DW-1:0]   cfg_wdata,
  output logic                tri_we,
  output logic                pal_we,
  output logic [CFG_AW-1:0]   tbl_addr,
  output logic [CFG_DW-1:0]   tri_wdata,
  output shade_pkg::rgb565_t  pal_wdata,
  output logic [15:0]         ambient,
  output logic                cull_en
);

  logic ctrl_we;  // write to the control word

  // steer the strobe by target, tables write on this same edge
  assign tri_we  = cfg_we && (cfg_sel == shade_pkg::CFG_SEL_TRI);
  assign pal_we  = cfg_we && (cfg_sel == shade_pkg::CFG_SEL_PAL);
  assign ctrl_we = cfg_we && (cfg_sel == shade_pkg::CFG_SEL_CTRL);

  // both tables share address and data lines
  assign tbl_addr  = cfg_addr;
  assign tri_wdata = cfg_wdata;        // {color index, normal}
  assign pal_wdata = cfg_wdata[15:0];  // rgb565 in the low half

  // control word, used from the next cycle
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      ambient <= '0;    // no ambient light
      cull_en <= 1'b1;  // back faces dropped by default
    end else if (ctrl_we) begin
      ambient <= cfg_wdata[15:0];
      cull_en <= cfg_wdata[shade_pkg::CTRL_CULL_BIT];
    end
  end

  // light_dot floors at ambient before it clamps, keep ambient in range
  a_ambient_legal : assert property (
    @(posedge clk_in) disable iff (rst_in)
    ctrl_we |-> (cfg_wdata[15:0] <= shade_pkg::INTENSITY_ONE)
  ) else $error("shade_cfg_regs: ambient %0d above 1.0", cfg_wdata[15:0]);

endmodule

`default_nettype wire

// File: hdl/flat_shader.sv
// fixed 6-cycle latency, one pixel per cycle, no back-pressure; only cfg writes change the tables
`default_nettype none

module flat_shader #(
  parameter int  NUM_TRI    = 2048,
  parameter int  NUM_COLORS = 256,
  localparam int TRI_AW     = $clog2(NUM_TRI),
  localparam int CIDX_W     = $clog2(NUM_COLORS),
  localparam int CFG_AW     = (TRI_AW > CIDX_W) ? TRI_AW : CIDX_W,
  localparam int NRM_W      = 3 * shade_pkg::NORMAL_W,
  localparam int CFG_DW     = NRM_W + CIDX_W
) (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                valid_in,
  input  logic [TRI_AW-1:0]   tri_id,
  input  shade_pkg::normal_t  cam_normal,
  input  logic                tri_we,
  input  logic                pal_we,
  input  logic [CFG_AW-1:0]   tbl_addr,
  input  logic [CFG_DW-1:0]   tri_wdata,
  input  shade_pkg::rgb565_t  pal_wdata,
  input  logic [15:0]         ambient,
  input  logic                cull_en,
  output shade_pkg::rgb565_t  color,
  output logic                valid_out
);

  logic [CFG_DW-1:0]   tri_entry;   // T+1, {color index, normal}
  logic [CIDX_W-1:0]   color_idx;
  shade_pkg::normal_t  tri_normal;
  shade_pkg::normal_t  cam_normal_d;  // T+1
  shade_pkg::rgb565_t  base_color;    // T+2
  shade_pkg::rgb565_t  base_color_d;  // T+4
  logic [15:0]         intensity;     // T+4
  logic                front;         // T+4
  logic                valid_d4;      // T+4, before the cull test
  logic                keep;
  logic [4:0]          red_s;         // T+6
  logic [5:0]          green_s;
  logic [4:0]          blue_s;

  // triangle table, addressed by the pixel's triangle
  table_ram #(
    .DEPTH(NUM_TRI),
    .WIDTH(CFG_DW)
  ) tri_table (
    .clk_in (clk_in),
    .we     (tri_we),
    .waddr  (tbl_addr[TRI_AW-1:0]),
    .wdata  (tri_wdata),
    .raddr  (tri_id),
    .rdata  (tri_entry)
  );

  assign color_idx  = tri_entry[CFG_DW-1:NRM_W];  // only one index per triangle
  assign tri_normal = tri_entry[NRM_W-1:0];

  // palette, addressed by the entry's color index
  table_ram #(
    .DEPTH(NUM_COLORS),
    .WIDTH($bits(shade_pkg::rgb565_t))
  ) palette (
    .clk_in (clk_in),
    .we     (pal_we),
    .waddr  (tbl_addr[CIDX_W-1:0]),
    .wdata  (pal_wdata),
    .raddr  (color_idx),
    .rdata  (base_color)
  );

  // camera normal waits for the table read
  delay_line #(
    .STAGES(1),
    .T(shade_pkg::normal_t)
  ) cam_normal_dly (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .d      (cam_normal),
    .q      (cam_normal_d)
  );

  // T+1 to T+4
  light_dot u_light (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .tri_normal (tri_normal),
    .cam_normal (cam_normal_d),
    .ambient    (ambient),
    .intensity  (intensity),
    .front      (front)
  );

  // palette color held until the intensity is ready
  delay_line #(
    .STAGES(2),
    .T(shade_pkg::rgb565_t)
  ) color_dly (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .d      (base_color),
    .q      (base_color_d)
  );

  // one scaler per channel, T+4 to T+6
  channel_scale #(.CH_W(5)) red_scale (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .channel   (base_color_d.r),
    .intensity (intensity),
    .scaled    (red_s)
  );

  channel_scale #(.CH_W(6)) green_scale (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .channel   (base_color_d.g),
    .intensity (intensity),
    .scaled    (green_s)
  );

  channel_scale #(.CH_W(5)) blue_scale (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .channel   (base_color_d.b),
    .intensity (intensity),
    .scaled    (blue_s)
  );

  assign color = {red_s, green_s, blue_s};  // meaningful only with valid_out

  // valid rides alongside until the facing flag shows up
  delay_line #(
    .STAGES(4),
    .T(logic)
  ) valid_pre_dly (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .d      (valid_in),
    .q      (valid_d4)
  );

  assign keep = valid_d4 && (!cull_en || front);  // drop back faces when culling

  // then follows the channel scalers
  delay_line #(
    .STAGES(2),
    .T(logic)
  ) valid_post_dly (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .d      (keep),
    .q      (valid_out)
  );

  // an unknown strobe means a table was read before it was loaded
  a_valid_known : assert property (
    @(posedge clk_in) disable iff (rst_in) !$isunknown(valid_out)
  ) else $error("flat_shader: valid_out unknown");

endmodule

`default_nettype wire

// File: hdl/shade_top.sv
// load both tables through cfg before sending pixels; cfg_wdata is 48 normal bits plus the color index
`default_nettype none

module shade_top #(
  parameter int  NUM_TRI    = 2048,
  parameter int  NUM_COLORS = 256,
  localparam int TRI_AW     = $clog2(NUM_TRI),
  localparam int CIDX_W     = $clog2(NUM_COLORS),
  localparam int CFG_AW     = (TRI_AW > CIDX_W) ? TRI_AW : CIDX_W,
  localparam int CFG_DW     = 3 * shade_pkg::NORMAL_W + CIDX_W
) (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                valid_in,
  input  logic [TRI_AW-1:0]   tri_id,
  input  shade_pkg::normal_t  cam_normal,
  input  logic                cfg_we,
  input  logic [1:0]          cfg_sel,
  input  logic [CFG_AW-1:0]   cfg_addr,
  input  logic [CFG_DW-1:0]   cfg_wdata,
  output shade_pkg::rgb565_t  color,
  output logic                valid_out
);

  logic               tri_we;
  logic               pal_we;
  logic [CFG_AW-1:0]  tbl_addr;
  logic [CFG_DW-1:0]  tri_wdata;
  shade_pkg::rgb565_t pal_wdata;
  logic [15:0]        ambient;
  logic               cull_en;

  shade_cfg_regs #(
    .NUM_TRI(NUM_TRI),
    .NUM_COLORS(NUM_COLORS)
  ) u_cfg (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .cfg_we    (cfg_we),
    .cfg_sel   (cfg_sel),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .tri_we    (tri_we),
    .pal_we    (pal_we),
    .tbl_addr  (tbl_addr),
    .tri_wdata (tri_wdata),
    .pal_wdata (pal_wdata),
    .ambient   (ambient),
    .cull_en   (cull_en)
  );

  flat_shader #(
    .NUM_TRI(NUM_TRI),
    .NUM_COLORS(NUM_COLORS)
  ) u_shader (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .valid_in   (valid_in),
    .tri_id     (tri_id),
    .cam_normal (cam_normal),
    .tri_we     (tri_we),
    .pal_we     (pal_we),
    .tbl_addr   (tbl_addr),
    .tri_wdata  (tri_wdata),
    .pal_wdata  (pal_wdata),
    .ambient    (ambient),
    .cull_en    (cull_en),
    .color      (color),
    .valid_out  (valid_out)
  );

endmodule

`default_nettype wire

// File: tb/shade_checks.svh
// included inside shade_tb; tasks drive its signals directly, one cfg write or pixel per clock
`ifndef SHADE_CHECKS_SVH
`define SHADE_CHECKS_SVH

  // strobe stays high until the next drive task or cfg_idle
  task automatic cfg_write(input logic [1:0] sel, input int addr, input logic [CFG_DW-1:0] data);
    @(posedge clk_in);
    cfg_we    <= 1'b1;
    cfg_sel   <= sel;
    cfg_addr  <= CFG_AW'(addr);
    cfg_wdata <= data;
  endtask

  task automatic cfg_idle();
    @(posedge clk_in);
    cfg_we <= 1'b0;
  endtask

  task automatic load_triangle(input int id, input shade_pkg::normal_t n, input int cidx);
    cfg_write(shade_pkg::CFG_SEL_TRI, id, {CIDX_W'(cidx), n});  // index above the normal
    model_normal[id] = n;
    model_cidx[id]   = CIDX_W'(cidx);
  endtask

  task automatic load_color(input int idx, input shade_pkg::rgb565_t c);
    cfg_write(shade_pkg::CFG_SEL_PAL, idx, CFG_DW'(c));
    model_pal[idx] = c;
  endtask

  task automatic set_control(input int amb, input bit cull);
    logic [CFG_DW-1:0] data;
    data = '0;
    data[15:0] = 16'(amb);
    data[shade_pkg::CTRL_CULL_BIT] = cull;
    cfg_write(shade_pkg::CFG_SEL_CTRL, 0, data);
    model_ambient = amb;
    model_cull    = cull;
  endtask

  function automatic shade_pkg::normal_t make_normal(input int x, input int y, input int z);
    shade_pkg::normal_t n;
    n.x = 16'(x);
    n.y = 16'(y);
    n.z = 16'(z);
    return n;
  endfunction

  function automatic shade_pkg::normal_t random_normal();
    int c [3];
    for (int i = 0; i < 3; i++) begin
      c[i] = int'($urandom_range(32768)) - 16384;  // -1.0 to 1.0
    end
    return make_normal(c[0], c[1], c[2]);
  endfunction

  // unshifted sum of component products, q4.28
  function automatic longint raw_dot(input shade_pkg::normal_t a, input shade_pkg::normal_t b);
    return longint'(a.x) * longint'(b.x) + longint'(a.y) * longint'(b.y)
         + longint'(a.z) * longint'(b.z);
  endfunction

  function automatic shade_pkg::rgb565_t expected_color(input shade_pkg::normal_t n,
      input shade_pkg::normal_t c, input int amb, input shade_pkg::rgb565_t base);
    longint inten;
    shade_pkg::rgb565_t res;
    inten = raw_dot(n, c) >>> shade_pkg::NORMAL_FRAC;  // floors toward -inf
    if (inten < amb) begin
      inten = amb;
    end
    if (inten > longint'(shade_pkg::INTENSITY_ONE)) begin
      inten = longint'(shade_pkg::INTENSITY_ONE);  // cap at 1.0
    end
    res.r = 5'((longint'(base.r) * inten) >> shade_pkg::NORMAL_FRAC);  // truncated
    res.g = 6'((longint'(base.g) * inten) >> shade_pkg::NORMAL_FRAC);
    res.b = 5'((longint'(base.b) * inten) >> shade_pkg::NORMAL_FRAC);
    return res;
  endfunction

  // one pixel in, expected color queued unless culled
  task automatic send_pixel(input int id, input shade_pkg::normal_t cam);
    shade_pkg::rgb565_t exp_c;
    @(posedge clk_in);
    valid_in   <= 1'b1;
    tri_id     <= TRI_AW'(id);
    cam_normal <= cam;
    if (!model_cull || raw_dot(model_normal[id], cam) > 0) begin
      exp_c = expected_color(model_normal[id], cam, model_ambient,
                             model_pal[model_cidx[id]]);
      exp_color_q.push_back(exp_c);
      exp_due_q.push_back(cycle + LATENCY + 1);  // monitor sees it one edge after it rises
    end
  endtask

  task automatic pixels_idle();
    @(posedge clk_in);
    valid_in <= 1'b0;
  endtask

  task automatic compare_color(input shade_pkg::rgb565_t got, input shade_pkg::rgb565_t exp);
    checked_count++;
    if (got !== exp) begin
      $display("** Error at %0d ns: color %h, expected %h", $time, got, exp);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    while (exp_due_q.size() > 0) begin
      @(posedge clk_in);
    end
    repeat (LATENCY + 2) @(posedge clk_in);  // window for stray strobes
    tests_run++;
    if (error_count == err_start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, error_count - err_start);
    end
  endtask

`endif

// File: tb/shade_tb.sv
// directed and random tests of shade_top; needs tb on the include path, ends with a pass or fail line
`default_nettype none

module shade_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TRI        = 2048;
  localparam int NUM_COLORS     = 256;
  localparam int TRI_AW         = $clog2(NUM_TRI);
  localparam int CIDX_W         = $clog2(NUM_COLORS);
  localparam int CFG_AW         = TRI_AW;  // triangle address is the wider one
  localparam int CFG_DW         = 3 * shade_pkg::NORMAL_W + CIDX_W;
  localparam int LATENCY        = 6;
  localparam int STREAM_PIXELS  = 200;
  localparam int TOTAL_PIXELS   = 8 + STREAM_PIXELS;  // directed pixels plus the stream
  localparam int TIMEOUT_CYCLES = TOTAL_PIXELS * 8 + 200;

  logic               clk_in;
  logic               rst_in;
  logic               valid_in;
  logic [TRI_AW-1:0]  tri_id;
  shade_pkg::normal_t cam_normal;
  logic               cfg_we;
  logic [1:0]         cfg_sel;
  logic [CFG_AW-1:0]  cfg_addr;
  logic [CFG_DW-1:0]  cfg_wdata;
  shade_pkg::rgb565_t color;
  logic               valid_out;

  // testbench copy of tables and control
  shade_pkg::normal_t model_normal [NUM_TRI];
  logic [CIDX_W-1:0]  model_cidx [NUM_TRI];
  shade_pkg::rgb565_t model_pal [NUM_COLORS];
  int                 model_ambient = 0;     // reset value
  bit                 model_cull    = 1'b1;  // cull on after reset

  shade_pkg::rgb565_t exp_color_q [$];
  int                 exp_due_q [$];  // cycle the strobe should be seen

  int cycle         = 0;
  int error_count   = 0;
  int checked_count = 0;
  int tests_run     = 0;
  int tests_failed  = 0;

  `include "shade_checks.svh"

  shade_top #(
    .NUM_TRI(NUM_TRI),
    .NUM_COLORS(NUM_COLORS)
  ) u_dut (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .valid_in   (valid_in),
    .tri_id     (tri_id),
    .cam_normal (cam_normal),
    .cfg_we     (cfg_we),
    .cfg_sel    (cfg_sel),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .color      (color),
    .valid_out  (valid_out)
  );

  initial begin
    clk_in = 1'b0;
    forever #20 clk_in = ~clk_in;  // 40 ns period
  end

  // cycle count and watchdog
  always @(posedge clk_in) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cycle);
      $display(">>> FAIL");
      $finish;
    end
  end

  // output monitor, strobes matched in order against the queue
  always @(posedge clk_in) begin
    if (!rst_in) begin
      if (valid_out) begin
        if (exp_color_q.size() == 0) begin
          $display("extra valid_out at %0d ns with no pixel expected", $time);
          error_count++;
        end else begin
          if (exp_due_q[0] != cycle) begin
            $display("valid_out at cycle %0d, expected at cycle %0d", cycle, exp_due_q[0]);
            error_count++;
          end
          compare_color(color, exp_color_q.pop_front());
          void'(exp_due_q.pop_front());
        end
      end else if (exp_due_q.size() > 0 && exp_due_q[0] <= cycle) begin
        $display("missing valid_out for the pixel due at cycle %0d", exp_due_q[0]);
        error_count++;
        void'(exp_color_q.pop_front());
        void'(exp_due_q.pop_front());
      end
    end
  end

  // full light gives the palette color back
  task automatic lit_color();
    int err_start;
    err_start = error_count;
    load_color(3, 16'hA5C3);
    load_color(4, 16'hFFFF);
    load_triangle(10, make_normal(0, 0, 16384), 3);
    load_triangle(11, make_normal(0, 16384, 0), 4);
    cfg_idle();
    send_pixel(10, make_normal(0, 0, 16384));
    send_pixel(11, make_normal(0, 16384, 0));
    pixels_idle();
    finish_test("lit color", err_start);
  endtask

  task automatic partial_light();
    int err_start;
    err_start = error_count;
    load_color(5, 16'hFFFF);
    load_color(6, 16'h7BEF);
    load_color(7, 16'hF7DE);  // even channels end just below a whole value at half light
    load_triangle(20, make_normal(11585, 0, 11585), 7);  // ~0.707 each
    load_triangle(21, make_normal(9459, 9459, 9459), 6);
    load_triangle(22, make_normal(16000, -3000, 2000), 5);
    cfg_idle();
    send_pixel(20, make_normal(5792, 0, 5792));  // sum just under one half
    send_pixel(21, make_normal(0, 0, 16384));
    send_pixel(22, make_normal(8000, 4000, 10000));
    pixels_idle();
    finish_test("partial light", err_start);
  endtask

  task automatic ambient_floor();
    int err_start;
    err_start = error_count;
    set_control(4096, 1'b1);  // quarter ambient
    load_triangle(30, make_normal(0, 0, 16384), 5);
    cfg_idle();
    send_pixel(30, make_normal(0, 0, 1000));  // dim but front-facing
    pixels_idle();
    finish_test("ambient floor", err_start);
  endtask

  task automatic back_face_cull();
    int err_start;
    err_start = error_count;
    set_control(4096, 1'b1);
    load_triangle(40, make_normal(0, 0, -16384), 6);  // faces away
    cfg_idle();
    send_pixel(40, make_normal(0, 0, 16384));  // dropped
    pixels_idle();
    repeat (LATENCY + 2) @(posedge clk_in);
    set_control(4096, 1'b0);
    cfg_idle();
    send_pixel(40, make_normal(0, 0, 16384));  // now kept at ambient
    pixels_idle();
    finish_test("back face cull", err_start);
  endtask

  task automatic random_stream();
    int err_start;
    err_start = error_count;
    set_control($urandom_range(8192), 1'b1);
    for (int i = 0; i < 16; i++) begin
      load_color(i, 16'($urandom));
    end
    for (int i = 0; i < 32; i++) begin
      load_triangle(100 + i, random_normal(), $urandom_range(15));
    end
    cfg_idle();
    for (int i = 0; i < STREAM_PIXELS; i++) begin
      send_pixel(100 + $urandom_range(31), random_normal());  // back to back
    end
    pixels_idle();
    finish_test("random stream", err_start);
  endtask

  initial begin
    void'($urandom(17));
    rst_in     = 1'b1;
    valid_in   = 1'b0;
    tri_id     = '0;
    cam_normal = '0;
    cfg_we     = 1'b0;
    cfg_sel    = '0;
    cfg_addr   = '0;
    cfg_wdata  = '0;
    repeat (5) @(posedge clk_in);
    rst_in <= 1'b0;
    lit_color();
    partial_light();
    ambient_floor();
    back_face_cull();
    random_stream();
    $display("tests %0d, failed %0d, colors checked %0d, errors %0d",
             tests_run, tests_failed, checked_count, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+tb
hdl/shade_pkg.sv
hdl/delay_line.sv
hdl/table_ram.sv
hdl/light_dot.sv
hdl/channel_scale.sv
hdl/shade_cfg_regs.sv
hdl/flat_shader.sv
hdl/shade_top.sv
tb/shade_tb.sv
